// File: all.f
+incdir+tb
verilog/rvPkg.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/execUnit.sv
verilog/memWbUnit.sv
verilog/rvPipeline.sv
tb/tbRvPipeline.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
mkdir -p build
rm -f build/sim.log
verilator --binary --assert -f all.f --top-module tbRvPipeline -Mdir build -o simv \
    && ./build/simv > build/sim.log \
    || { cat build/sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat build/sim.log
grep -q "^test passed$" build/sim.log \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }

// File: tb/tbRefModel.svh
// Included inside the testbench module; expects imem, prog, seed, expAddr, expData and ResetPc
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ========================================
// Instruction encoders
// ========================================
function automatic wordT rType(wordT f7, wordT f3, wordT rd, wordT rs1, wordT rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic wordT iType(wordT op, wordT f3, wordT rd, wordT rs1, wordT imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

// sw only
function automatic wordT sType(wordT rs2, wordT rs1, wordT imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic wordT bType(wordT f3, wordT rs1, wordT rs2, wordT imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic wordT jType(wordT rd, wordT imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
endfunction

// Depends on every address bit
function automatic wordT fillWord(int idx);
    wordT w;
    w = idx;
    return (w + 32'd1) * 32'h9E37_79B9;
endfunction

// ========================================
// Programs, each ending in a jal-to-self
// ========================================
function automatic void aluProgram();
    int   rF3 [9] = '{0, 0, 2, 4, 6, 7, 1, 5, 5};
    int   rAlt [9] = '{0, 1, 0, 0, 0, 0, 0, 0, 1};
    int   iF3 [8] = '{0, 2, 4, 6, 7, 1, 5, 5};
    int   sa;
    wordT ra, rb, rc, imm;
    sa = 32'h200;
    for (int round = 0; round < 2; round++) begin
        ra = $random(seed);
        rb = $random(seed);
        rc = $random(seed);
        // Widen x1 past 12 bits with a shift and an xor
        prog.push_back(iType(32'h13, 0, 1, 0, ra));
        prog.push_back(iType(32'h13, 1, 1, 1, rc & 31));
        prog.push_back(iType(32'h13, 4, 1, 1, rc >> 8));
        prog.push_back(iType(32'h13, 0, 2, 0, rb));
        for (int k = 0; k < 9; k++) begin
            prog.push_back(rType(rAlt[k] != 0 ? 32 : 0, rF3[k], 3, 1, 2));
            prog.push_back(sType(3, 0, sa));
            sa += 4;
        end
        for (int k = 0; k < 8; k++) begin
            imm = $random(seed);
            if (iF3[k] == 1 || iF3[k] == 5) begin
                imm = (imm & 31) | ((k == 7) ? 32'h400 : 32'h0);
            end
            prog.push_back(iType(32'h13, iF3[k], 3, 1, imm));
            prog.push_back(sType(3, 0, sa));
            sa += 4;
        end
    end
    prog.push_back(jType(0, 0));
endfunction

function automatic void forwardProgram();
    prog.push_back(iType(32'h13, 0, 1, 0, 100));
    prog.push_back(iType(32'h13, 0, 2, 1, -3));
    prog.push_back(rType(0, 0, 3, 1, 2));
    prog.push_back(rType(32, 0, 4, 1, 3));
    prog.push_back(rType(0, 4, 5, 2, 4));
    prog.push_back(rType(0, 6, 6, 3, 4));
    prog.push_back(sType(3, 0, 32'h300));
    prog.push_back(sType(4, 0, 32'h304));
    prog.push_back(sType(5, 0, 32'h308));
    prog.push_back(sType(6, 0, 32'h30C));
    prog.push_back(iType(32'h13, 0, 7, 6, 1));
    prog.push_back(sType(7, 0, 32'h310));
    prog.push_back(jType(0, 0));
endfunction

function automatic void loadUseProgram();
    prog.push_back(iType(32'h13, 0, 1, 0, 291));
    prog.push_back(sType(1, 0, 32'h80));
    prog.push_back(iType(32'h03, 2, 2, 0, 32'h80));
    prog.push_back(rType(0, 0, 3, 2, 1));
    prog.push_back(sType(3, 0, 32'h84));
    // Store data taken straight from a load
    prog.push_back(iType(32'h03, 2, 4, 0, 32'h90));
    prog.push_back(sType(4, 0, 32'h94));
    prog.push_back(iType(32'h03, 2, 5, 0, 32'h98));
    prog.push_back(iType(32'h13, 0, 6, 5, 5));
    prog.push_back(sType(6, 0, 32'h9C));
    prog.push_back(jType(0, 0));
endfunction

// beq taken, bne taken, beq not taken, bne not taken
function automatic void branchProgram();
    prog.push_back(iType(32'h13, 0, 1, 0, 5));
    prog.push_back(iType(32'h13, 0, 2, 0, 5));
    prog.push_back(iType(32'h13, 0, 3, 0, 7));
    for (int b = 0; b < 4; b++) begin
        prog.push_back(bType(b % 2, 1, (b == 0 || b == 3) ? 2 : 3, 12));
        for (int j = 0; j < 3; j++) begin
            prog.push_back(sType(j + 1, 0, 32'h100 + 12 * b + 4 * j));
        end
    end
    prog.push_back(jType(0, 0));
endfunction

function automatic void jalProgram();
    prog.push_back(iType(32'h13, 0, 1, 0, 9));
    prog.push_back(jType(5, 12));
    prog.push_back(sType(1, 0, 32'h180));
    prog.push_back(sType(1, 0, 32'h184));
    prog.push_back(sType(5, 0, 32'h188));
    prog.push_back(jType(6, 8));
    prog.push_back(sType(1, 0, 32'h18C));
    prog.push_back(sType(6, 0, 32'h190));
    prog.push_back(rType(0, 0, 7, 5, 6));
    prog.push_back(sType(7, 0, 32'h194));
    prog.push_back(jType(0, 0));
endfunction

// ========================================
// Architectural model
// ========================================
function automatic wordT aluResult(wordT a, wordT b, logic [2:0] f3, logic alt);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// One instruction per step; returns the store count, or -1 if the self-loop never comes
function automatic int runReference();
    wordT x [32];
    wordT mem [256];
    wordT pc, nextPc, ins, a, b, ea;
    wordT iImm, sImm, bImm, jImm;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        mem[i] = fillWord(i);
    end
    expAddr.delete();
    expData.delete();
    pc = ResetPc;
    for (int step = 0; step < 4000; step++) begin
        ins    = imem[pc[9:2]];
        a      = x[ins[19:15]];
        b      = x[ins[24:20]];
        iImm   = {{20{ins[31]}}, ins[31:20]};
        sImm   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bImm   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        jImm   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = pc + 32'd4;
        case (ins[6:0])
            7'h33: x[ins[11:7]] = aluResult(a, b, ins[14:12], ins[30]);
            7'h13: x[ins[11:7]] = aluResult(a, iImm, ins[14:12],
                                            ins[30] && ins[14:12] == 3'b101);
            7'h03: begin
                ea = a + iImm;
                x[ins[11:7]] = mem[ea[9:2]];
            end
            7'h23: begin
                ea = a + sImm;
                mem[ea[9:2]] = b;
                expAddr.push_back(ea);
                expData.push_back(b);
            end
            7'h63: if ((a == b) != ins[12]) nextPc = pc + bImm;
            7'h6F: begin
                if (jImm == '0) begin
                    return expAddr.size();
                end
                x[ins[11:7]] = pc + 32'd4;
                nextPc = pc + jImm;
            end
            default: ;
        endcase
        x[0] = '0;
        pc   = nextPc;
    end
    return -1;
endfunction

`endif

// File: tb/tbRvPipeline.sv
// Memories are 256 words each, addressed by word index bits 9:2; programs start at ResetPc
`timescale 1ns/1ps

module tbRvPipeline import rvPkg::*; ();

    localparam pcT ResetPc = 32'h0000_0040;

    logic     clk;
    logic     rst_n;
    pcT       imemAddr;
    wordT     imemRdata;
    logic     dmemRen;
    logic     dmemWen;
    dmemAddrT dmemAddr;
    wordT     dmemWdata;
    wordT     dmemRdata;

    wordT imem [256];
    wordT dmem [256];
    wordT prog [$];
    wordT expAddr [$];
    wordT expData [$];
    int   seed;
    int   storeIdx = 0;
    int   cmpErrors = 0;
    int   passCount;
    int   failCount;

    `include "tbRefModel.svh"

    rvPipeline #(
        .ResetPc(ResetPc)
    ) u_rvPipeline (
        .clk(clk),
        .rst_n(rst_n),
        .imemAddr(imemAddr),
        .imemRdata(imemRdata),
        .dmemRen(dmemRen),
        .dmemWen(dmemWen),
        .dmemAddr(dmemAddr),
        .dmemWdata(dmemWdata),
        .dmemRdata(dmemRdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // Memory models
    // ========================================
    assign imemRdata = imem[imemAddr[9:2]];
    // Read data only while the read strobe is up
    assign dmemRdata = dmemRen ? dmem[dmemAddr[7:0]] : '0;

    // Refilled on every reset cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dmemWen) begin
            dmem[dmemAddr[7:0]] <= dmemWdata;
        end
    end

    // ========================================
    // Store comparison
    // ========================================
    always @(negedge clk) begin : compareStores
        wordT ea;
        if (!rst_n) begin
            storeIdx = 0;
        end else if (dmemWen) begin
            extraOk: assert (storeIdx < expAddr.size())
                else begin
                    $display("Unexpected store at %0t: word %h written after all %0d expected",
                             $time, dmemAddr, expAddr.size());
                    cmpErrors++;
                end
            if (storeIdx < expAddr.size()) begin
                ea = expAddr[storeIdx];
                storeOk: assert (dmemAddr == ea[31:2] && dmemWdata == expData[storeIdx])
                    else begin
                        $display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                                 $time, storeIdx, dmemWdata, dmemAddr, expData[storeIdx],
                                 ea[31:2]);
                        cmpErrors++;
                    end
            end
            storeIdx++;
        end
    end

    function automatic int idleAtReset(string name);
        int bad;
        bad = 0;
        idleOk: assert (!dmemWen && !dmemRen && imemAddr == ResetPc)
            else begin
                $display("** Error at %0t: %s: reset state wrong, wen %b ren %b fetch %h",
                         $time, name, dmemWen, dmemRen, imemAddr);
                bad = 1;
            end
        return bad;
    endfunction

    task automatic runProgram(string name, int which);
        int   errBase;
        int   localErr;
        int   expCount;
        int   cycles;
        wordT at;
        @(posedge clk);
        rst_n    <= 1'b0;
        errBase  = cmpErrors;
        localErr = 0;
        prog.delete();
        case (which)
            0: aluProgram();
            1: forwardProgram();
            2: loadUseProgram();
            3: branchProgram();
            default: jalProgram();
        endcase
        // Unused words hold addi x0,x0,index
        for (int i = 0; i < 256; i++) begin
            imem[i] = iType(32'h13, 0, 0, 0, i);
        end
        for (int k = 0; k < prog.size(); k++) begin
            at = ResetPc + k * 4;
            imem[at[9:2]] = prog[k];
        end
        expCount = runReference();
        refOk: assert (expCount > 0)
            else begin
                $display("%s: reference model never reached the final self-loop", name);
                localErr++;
            end
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            localErr += idleAtReset(name);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        localErr += idleAtReset(name);
        cycles = 0;
        while (storeIdx < expCount && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        doneOk: assert (storeIdx >= expCount)
            else begin
                $display("%s: timed out after %0d cycles with %0d of %0d stores seen",
                         name, cycles, storeIdx, expCount);
                localErr++;
            end
        // Let squashed or stray stores show up
        repeat (12) @(posedge clk);
        localErr += cmpErrors - errBase;
        if (localErr == 0) begin
            passCount++;
            $display("%s: ok, %0d stores matched", name, storeIdx);
        end else begin
            failCount++;
            $display("%s: FAILED with %0d errors", name, localErr);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        rst_n     = 1'b0;
        seed      = 15123;
        passCount = 0;
        failCount = 0;
        runProgram("alu", 0);
        runProgram("forwarding", 1);
        runProgram("load-use", 2);
        runProgram("branches", 3);
        runProgram("jal", 4);
        $display("summary: %0d programs clean, %0d with errors", passCount, failCount);
        if (failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog/rvPipeline.sv
// Both memories must answer combinationally in the same cycle and never stall the core
`timescale 1ns/1ps

module rvPipeline import rvPkg::*; #(
    parameter pcT ResetPc = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    output pcT       imemAddr,
    input  wordT     imemRdata,
    output logic     dmemRen,
    output logic     dmemWen,
    output dmemAddrT dmemAddr,
    output wordT     dmemWdata,
    input  wordT     dmemRdata
);

    // ========================================
    // Stage interconnect
    // ========================================
    wordT    ifIdInstr;
    pcT      ifIdPc;
    logic    loadUseStall;
    logic    redirect;
    pcT      redirectPc;
    regAddrT rs1, rs2;
    wordT    rs1Data, rs2Data;
    regAddrT idExRd, idExRs1, idExRs2;
    pcT      idExPc;
    wordT    idExA, idExB, idExImm;
    aluFuncE idExAluFunc;
    logic    idExAluSrc, idExRegWrite, idExMemRead, idExMemWrite;
    logic    idExBranch, idExBne, idExJal, idExMemToReg;
    fwdSelT  fwdA, fwdB;
    wordT    exMemAlu, exMemStore, exMemLink;
    regAddrT exMemRd;
    logic    exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg, exMemJal;
    logic    wbEn;
    regAddrT wbRd;
    wordT    wbData;

    // Data port is driven straight from EX/MEM
    assign dmemRen   = exMemMemRead;
    assign dmemWen   = exMemMemWrite;
    assign dmemAddr  = exMemAlu[XLen-1:2];
    assign dmemWdata = exMemStore;

    // ========================================
    // Stages
    // ========================================
    fetchUnit #(
        .ResetPc(ResetPc)
    ) u_fetchUnit (.*);

    decodeUnit u_decodeUnit (.*);

    regFile u_regFile (.*);

    hazardUnit u_hazardUnit (.*);

    execUnit u_execUnit (.*);

    memWbUnit u_memWbUnit (.*);

endmodule

// File: verilog/memWbUnit.sv
// Load data is taken as a full word; no byte or halfword extraction
`timescale 1ns/1ps

module memWbUnit import rvPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  wordT    exMemAlu,
    input  wordT    exMemLink,
    input  regAddrT exMemRd,
    input  logic    exMemRegWrite,
    input  logic    exMemMemToReg,
    input  logic    exMemJal,
    input  wordT    dmemRdata,
    output logic    wbEn,
    output regAddrT wbRd,
    output wordT    wbData
);

    wordT memWbAlu, memWbRdata, memWbLink;
    logic memWbMemToReg, memWbJal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbEn          <= 1'b0;
            memWbMemToReg <= 1'b0;
            memWbJal      <= 1'b0;
        end else begin
            wbEn          <= exMemRegWrite;
            memWbMemToReg <= exMemMemToReg;
            memWbJal      <= exMemJal;
        end
    end

    always_ff @(posedge clk) begin
        memWbAlu   <= exMemAlu;
        memWbRdata <= dmemRdata;
        memWbLink  <= exMemLink;
        wbRd       <= exMemRd;
    end

    // Link value for jal, else load data or ALU result
    assign wbData = memWbJal ? memWbLink :
                    memWbMemToReg ? memWbRdata : memWbAlu;

endmodule

// File: verilog/execUnit.sv
// Branches and jal resolve here; only beq and bne are compared, target is always pc plus immediate
`timescale 1ns/1ps

module execUnit import rvPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  pcT      idExPc,
    input  wordT    idExA,
    input  wordT    idExB,
    input  wordT    idExImm,
    input  aluFuncE idExAluFunc,
    input  regAddrT idExRd,
    input  logic    idExAluSrc, idExRegWrite, idExMemRead, idExMemWrite,
    input  logic    idExBranch, idExBne, idExJal, idExMemToReg,
    input  fwdSelT  fwdA,
    input  fwdSelT  fwdB,
    input  wordT    wbData,
    output logic    redirect,
    output pcT      redirectPc,
    output wordT    exMemAlu,
    output wordT    exMemStore,
    output wordT    exMemLink,
    output regAddrT exMemRd,
    output logic    exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg, exMemJal
);

    wordT opA, opB, aluB, aluOut;
    logic opEq;

    // ========================================
    // Operand forwarding
    // ========================================
    assign opA  = (fwdA == FwdMem) ? exMemAlu : (fwdA == FwdWb) ? wbData : idExA;
    assign opB  = (fwdB == FwdMem) ? exMemAlu : (fwdB == FwdWb) ? wbData : idExB;
    assign aluB = idExAluSrc ? idExImm : opB;

    always_comb begin
        case (idExAluFunc)
            AluAdd:  aluOut = opA + aluB;
            AluSub:  aluOut = opA - aluB;
            AluSlt:  aluOut = {31'd0, $signed(opA) < $signed(aluB)};
            AluXor:  aluOut = opA ^ aluB;
            AluOr:   aluOut = opA | aluB;
            AluAnd:  aluOut = opA & aluB;
            AluSll:  aluOut = opA << aluB[4:0];
            AluSrl:  aluOut = opA >> aluB[4:0];
            AluSra:  aluOut = $signed(opA) >>> aluB[4:0];
            default: aluOut = '0;
        endcase
    end

    // Branch resolution
    assign opEq       = (opA == opB);
    assign redirect   = idExJal || (idExBranch && (idExBne ? !opEq : opEq));
    assign redirectPc = idExPc + idExImm;

    // ========================================
    // EX/MEM register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMemRegWrite <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
            exMemMemToReg <= 1'b0;
            exMemJal      <= 1'b0;
        end else begin
            exMemRegWrite <= idExRegWrite;
            exMemMemRead  <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
            exMemMemToReg <= idExMemToReg;
            exMemJal      <= idExJal;
        end
    end

    always_ff @(posedge clk) begin
        exMemAlu   <= aluOut;
        exMemStore <= opB;
        exMemLink  <= idExPc + 32'd4;
        exMemRd    <= idExRd;
    end

    redirectSource: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> (idExBranch || idExJal))
        else $error("redirect without a branch or jal in execute");

endmodule

// File: verilog/hazardUnit.sv
// Only a load immediately ahead of its consumer stalls; all other RAW cases are forwarded
`timescale 1ns/1ps

module hazardUnit import rvPkg::*; (
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  regAddrT idExRd,
    input  regAddrT idExRs1,
    input  regAddrT idExRs2,
    input  logic    idExMemRead,
    input  regAddrT exMemRd,
    input  logic    exMemRegWrite,
    input  regAddrT wbRd,
    input  logic    wbEn,
    output logic    loadUseStall,
    output fwdSelT  fwdA,
    output fwdSelT  fwdB
);

    // Youngest producer wins
    function automatic fwdSelT pickFwd(regAddrT src);
        if (exMemRegWrite && exMemRd != '0 && exMemRd == src) begin
            return FwdMem;
        end else if (wbEn && wbRd != '0 && wbRd == src) begin
            return FwdWb;
        end
        return FwdNone;
    endfunction

    assign loadUseStall = idExMemRead && idExRd != '0 &&
                          (idExRd == rs1 || idExRd == rs2);

    assign fwdA = pickFwd(idExRs1);
    assign fwdB = pickFwd(idExRs2);

endmodule

// File: verilog/regFile.sv
// Two combinational read ports and one write port; a same-cycle write is visible on the reads
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  logic    wbEn,
    input  regAddrT wbRd,
    input  wordT    wbData,
    output wordT    rs1Data,
    output wordT    rs2Data
);

    wordT regs [32];

    // x0 reads zero, then write-through, then the stored value
    assign rs1Data = (rs1 == '0) ? '0 :
                     (wbEn && wbRd == rs1) ? wbData : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 :
                     (wbEn && wbRd == rs2) ? wbData : regs[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

endmodule

// File: verilog/decodeUnit.sv
// Opcodes outside the RV32I subset decode as bubbles; funct3 is assumed legal for the opcode
`timescale 1ns/1ps

module decodeUnit import rvPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  wordT    ifIdInstr,
    input  pcT      ifIdPc,
    input  wordT    rs1Data,
    input  wordT    rs2Data,
    input  logic    loadUseStall,
    input  logic    redirect,
    output regAddrT rs1,
    output regAddrT rs2,
    output regAddrT idExRd,
    output regAddrT idExRs1,
    output regAddrT idExRs2,
    output pcT      idExPc,
    output wordT    idExA,
    output wordT    idExB,
    output wordT    idExImm,
    output aluFuncE idExAluFunc,
    output logic    idExAluSrc, idExRegWrite, idExMemRead, idExMemWrite,
    output logic    idExBranch, idExBne, idExJal, idExMemToReg
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    immT        imm;
    aluFuncE    aluFunc;
    logic       aluSrc, regWrite, memRead, memWrite, branch, jal, memToReg;
    logic       bubble;

    assign opcode = ifIdInstr[6:2];
    assign funct3 = ifIdInstr[14:12];
    assign rs1    = ifIdInstr[19:15];
    assign rs2    = ifIdInstr[24:20];
    assign bubble = loadUseStall | redirect;

    // ========================================
    // Main control
    // ========================================
    always_comb begin
        case (opcode)
            OpOp:     {aluSrc, regWrite, memRead, memWrite, branch, jal, memToReg} = 7'b0100000;
            OpImm:    {aluSrc, regWrite, memRead, memWrite, branch, jal, memToReg} = 7'b1100000;
            OpLoad:   {aluSrc, regWrite, memRead, memWrite, branch, jal, memToReg} = 7'b1110001;
            OpStore:  {aluSrc, regWrite, memRead, memWrite, branch, jal, memToReg} = 7'b1001000;
            OpBranch: {aluSrc, regWrite, memRead, memWrite, branch, jal, memToReg} = 7'b0000100;
            OpJal:    {aluSrc, regWrite, memRead, memWrite, branch, jal, memToReg} = 7'b0100010;
            default:  {aluSrc, regWrite, memRead, memWrite, branch, jal, memToReg} = 7'b0000000;
        endcase
    end

    // I, S, B and J formats
    always_comb begin
        case (opcode)
            OpImm, OpLoad: imm = {{20{ifIdInstr[31]}}, ifIdInstr[31:20]};
            OpStore:  imm = {{20{ifIdInstr[31]}}, ifIdInstr[31:25], ifIdInstr[11:7]};
            OpBranch: imm = {{20{ifIdInstr[31]}}, ifIdInstr[7], ifIdInstr[30:25],
                             ifIdInstr[11:8], 1'b0};
            OpJal:    imm = {{12{ifIdInstr[31]}}, ifIdInstr[19:12], ifIdInstr[20],
                             ifIdInstr[30:21], 1'b0};
            default:  imm = '0;
        endcase
    end

    // funct7 only matters for R-type and for srai among the immediates
    always_comb begin
        case (opcode)
            OpOp:     aluFunc = aluFuncE'({ifIdInstr[30], funct3});
            OpImm:    aluFunc = aluFuncE'({ifIdInstr[30] & (funct3 == 3'b101), funct3});
            OpBranch: aluFunc = AluSub;
            default:  aluFunc = AluAdd;
        endcase
    end

    // ========================================
    // ID/EX register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idExAluSrc   <= 1'b0;
            idExRegWrite <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExBranch   <= 1'b0;
            idExJal      <= 1'b0;
            idExMemToReg <= 1'b0;
        end else begin
            idExAluSrc   <= aluSrc & ~bubble;
            idExRegWrite <= regWrite & ~bubble;
            idExMemRead  <= memRead & ~bubble;
            idExMemWrite <= memWrite & ~bubble;
            idExBranch   <= branch & ~bubble;
            idExJal      <= jal & ~bubble;
            idExMemToReg <= memToReg & ~bubble;
        end
    end

    always_ff @(posedge clk) begin
        idExPc      <= ifIdPc;
        idExA       <= rs1Data;
        idExB       <= rs2Data;
        idExImm     <= imm;
        idExAluFunc <= aluFunc;
        idExBne     <= funct3[0];
        idExRd      <= ifIdInstr[11:7];
        idExRs1     <= rs1;
        idExRs2     <= rs2;
    end

endmodule

// File: verilog/fetchUnit.sv
// Fixed 4-byte PC step; instruction memory data must be valid in the cycle the address is driven
`timescale 1ns/1ps

module fetchUnit import rvPkg::*; #(
    parameter pcT ResetPc = '0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic loadUseStall,
    input  logic redirect,
    input  pcT   redirectPc,
    input  wordT imemRdata,
    output pcT   imemAddr,
    output pcT   ifIdPc,
    output wordT ifIdInstr
);

    pcT pc;
    pcT nextPc;

    // Redirect wins over a load-use hold
    assign nextPc   = redirect ? redirectPc :
                      loadUseStall ? pc : pc + 32'd4;
    assign imemAddr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= ResetPc;
            ifIdPc    <= ResetPc;
            ifIdInstr <= NopInstr;
        end else begin
            pc <= nextPc;
            if (redirect) begin
                // Squash the instruction fetched under the taken branch
                ifIdInstr <= NopInstr;
            end else if (!loadUseStall) begin
                ifIdInstr <= imemRdata;
                ifIdPc    <= pc;
            end
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

// File: verilog/rvPkg.sv
// RV32I subset only (no compressed, jalr, CSR or byte/half memory access); widths are fixed at 32
package rvPkg;

    localparam int XLen = 32;

    typedef logic [XLen-1:0] wordT;
    typedef logic [XLen-1:0] pcT;
    typedef logic [4:0]      regAddrT;
    typedef logic [XLen-3:0] dmemAddrT;
    typedef logic [XLen-1:0] immT;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        AluAdd = 4'b0000,
        AluSub = 4'b1000,
        AluSlt = 4'b0010,
        AluXor = 4'b0100,
        AluOr  = 4'b0110,
        AluAnd = 4'b0111,
        AluSll = 4'b0001,
        AluSrl = 4'b0101,
        AluSra = 4'b1101
    } aluFuncE;

    typedef logic [1:0] fwdSelT;
    localparam fwdSelT FwdNone = 2'd0;
    localparam fwdSelT FwdWb   = 2'd1;
    localparam fwdSelT FwdMem  = 2'd2;

    // Opcode bits 6 to 2
    localparam logic [4:0] OpOp     = 5'b01100;
    localparam logic [4:0] OpImm    = 5'b00100;
    localparam logic [4:0] OpLoad   = 5'b00000;
    localparam logic [4:0] OpStore  = 5'b01000;
    localparam logic [4:0] OpBranch = 5'b11000;
    localparam logic [4:0] OpJal    = 5'b11011;

    // addi x0, x0, 0
    localparam wordT NopInstr = 32'h0000_0013;

endpackage
